/* hdl/usb_rx_pkg.sv */
// Constants and types shared by the full-speed USB receiver blocks
// Each module refers to these by scoped name, never by import
`default_nettype none

package usb_rx_pkg;

	// 96 MHz sampling of a 12 Mb/s line
	localparam int CLKS_PER_BIT = 8;
	// Mid-bit, counted from the synchronised edge
	localparam int SAMPLE_POINT = 3;
	localparam int TIMER_W = $clog2(CLKS_PER_BIT);

	// KJKJKJKK on the wire, assembled LSB first
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	localparam int FIFO_DEPTH = 8;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [2:0]
	{
		IDLE,
		SYNC_CHECK,
		RECEIVE,
		ERR_WAIT,
		EOP_WAIT
	} rx_state_e;

	// One decoded line event, either a data bit or an end-of-packet marker
	typedef struct packed
	{
		logic value;
		logic eop;
	} line_bit_t;

	typedef struct packed
	{
		logic [7:0] data;
	} rx_byte_t;

endpackage

`default_nettype wire

/* hdl/line_sampler.sv */
// Front end of the USB receiver
// Synchronises d_plus/d_minus, recovers bit timing from d_plus edges,
// decodes NRZI and flags SE0 as a single end-of-packet event
`timescale 1ns/100ps
`default_nettype none

module line_sampler (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  d_plus,
	input  logic                  d_minus,
	output logic                  bit_strobe,
	output usb_rx_pkg::line_bit_t bit_evt
);

	logic dp_meta;
	logic dp_sync;
	logic dp_prev;
	logic dm_meta;
	logic dm_sync;
	logic active;
	logic in_eop;
	logic last_level;
	logic [usb_rx_pkg::TIMER_W-1:0] timer;
	logic [usb_rx_pkg::TIMER_W-1:0] phase;
	logic edge_seen;
	logic se0;
	logic data_take;
	logic eop_take;

	// Two-flop synchronisers parked at idle J
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dp_meta <= 1'b1;
			dp_sync <= 1'b1;
			dp_prev <= 1'b1;
			dm_meta <= 1'b0;
			dm_sync <= 1'b0;
		end
		else
		begin
			dp_meta <= d_plus;
			dp_sync <= dp_meta;
			dp_prev <= dp_sync;
			dm_meta <= d_minus;
			dm_sync <= dm_meta;
		end
	end

	assign edge_seen = dp_sync != dp_prev;
	assign se0 = !dp_sync && !dm_sync;

	// Bit phase restarts at zero on every edge
	assign phase = edge_seen ? '0 : timer;

	assign data_take = active && !in_eop && (phase == usb_rx_pkg::SAMPLE_POINT);
	assign eop_take = active && !in_eop && se0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			timer <= '0;
			active <= 1'b0;
			in_eop <= 1'b0;
			last_level <= 1'b1;
		end
		else
		begin
			if (phase == usb_rx_pkg::CLKS_PER_BIT - 1)
				timer <= '0;
			else
				timer <= phase + 1'b1;

			if (!active)
			begin
				// Level before the opening edge is the reference for bit 0
				last_level <= dp_prev;
				if (edge_seen)
					active <= 1'b1;
			end
			else if (in_eop)
			begin
				// J after SE0 closes the packet
				if (dp_sync)
				begin
					active <= 1'b0;
					in_eop <= 1'b0;
				end
			end
			else if (eop_take)
				in_eop <= 1'b1;
			else if (data_take)
				last_level <= dp_sync;
		end
	end

	// In NRZI the same level as the previous bit is a 1
	assign bit_strobe = data_take || eop_take;
	assign bit_evt = '{value: !eop_take && (dp_sync == last_level), eop: eop_take};

	// SE0 starts on a bit boundary and never lands on the sample point
	a_strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(data_take && eop_take));

endmodule

`default_nettype wire

/* hdl/packet_control.sv */
// Receive state machine of the USB receiver
// Checks the sync byte, assembles data bytes LSB first and strobes each
// whole byte towards the FIFO; drives the rcving and r_error flags
`timescale 1ns/100ps
`default_nettype none

module packet_control (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  bit_strobe,
	input  usb_rx_pkg::line_bit_t bit_evt,
	output logic                  byte_strobe,
	output usb_rx_pkg::rx_byte_t  byte_out,
	output logic                  rcving,
	output logic                  r_error
);

	usb_rx_pkg::rx_state_e state;
	logic [7:0] shift_reg;
	logic [7:0] next_byte;
	logic [2:0] bit_cnt;
	logic [usb_rx_pkg::TIMER_W-1:0] wait_cnt;
	logic data_evt;
	logic eop_evt;
	logic last_bit;

	assign data_evt = bit_strobe && !bit_evt.eop;
	assign eop_evt = bit_strobe && bit_evt.eop;
	assign last_bit = bit_cnt == 3'd7;

	// New bit enters at the top so the first bit ends up in bit 0
	assign next_byte = {bit_evt.value, shift_reg[7:1]};

	always_ff @(posedge clk)
	begin
		if (data_evt)
			shift_reg <= next_byte;
		if (data_evt && last_bit)
			byte_out <= '{data: next_byte};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= usb_rx_pkg::IDLE;
			bit_cnt <= '0;
			wait_cnt <= '0;
			byte_strobe <= 1'b0;
			rcving <= 1'b0;
			r_error <= 1'b0;
		end
		else
		begin
			byte_strobe <= 1'b0;

			case (state)
				usb_rx_pkg::IDLE:
				begin
					// First bit of the packet is bit 0 of sync
					if (data_evt)
					begin
						state <= usb_rx_pkg::SYNC_CHECK;
						bit_cnt <= 3'd1;
					end
				end

				usb_rx_pkg::SYNC_CHECK:
				begin
					if (eop_evt)
					begin
						r_error <= 1'b1;
						bit_cnt <= '0;
						wait_cnt <= '0;
						state <= usb_rx_pkg::EOP_WAIT;
					end
					else if (data_evt)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
						begin
							if (next_byte == usb_rx_pkg::SYNC_BYTE)
							begin
								state <= usb_rx_pkg::RECEIVE;
								rcving <= 1'b1;
								r_error <= 1'b0;
							end
							else
							begin
								state <= usb_rx_pkg::ERR_WAIT;
								r_error <= 1'b1;
							end
						end
					end
				end

				usb_rx_pkg::RECEIVE:
				begin
					if (eop_evt)
					begin
						rcving <= 1'b0;
						// Partial byte is lost and flagged
						if (bit_cnt != 3'd0)
							r_error <= 1'b1;
						bit_cnt <= '0;
						wait_cnt <= '0;
						state <= usb_rx_pkg::EOP_WAIT;
					end
					else if (data_evt)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
							byte_strobe <= 1'b1;
					end
				end

				usb_rx_pkg::ERR_WAIT:
				begin
					// Rest of a bad packet is ignored
					if (eop_evt)
					begin
						bit_cnt <= '0;
						wait_cnt <= '0;
						state <= usb_rx_pkg::EOP_WAIT;
					end
				end

				usb_rx_pkg::EOP_WAIT:
				begin
					// Line sits in SE0 then J here, one bit time of quiet is enough
					wait_cnt <= wait_cnt + 1'b1;
					if (data_evt)
					begin
						state <= usb_rx_pkg::SYNC_CHECK;
						bit_cnt <= 3'd1;
					end
					else if (wait_cnt == usb_rx_pkg::CLKS_PER_BIT - 1)
						state <= usb_rx_pkg::IDLE;
				end

				default:
					state <= usb_rx_pkg::IDLE;
			endcase
		end
	end

	a_rcving_state: assert property (@(posedge clk) disable iff (!rst_n)
		rcving |-> state == usb_rx_pkg::RECEIVE);

	// Byte strobe comes from a data bit taken while receiving
	a_byte_in_receive: assert property (@(posedge clk) disable iff (!rst_n)
		byte_strobe |-> $past(bit_strobe && state == usb_rx_pkg::RECEIVE));

endmodule

`default_nettype wire

/* hdl/rx_fifo.sv */
// Byte FIFO at the output of the USB receiver, first word fall through
// r_data shows the oldest byte while empty is low, r_enable pops it;
// a byte pushed while full is dropped since the line cannot stall
`timescale 1ns/100ps
`default_nettype none

module rx_fifo (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 byte_strobe,
	input  usb_rx_pkg::rx_byte_t byte_in,
	input  logic                 r_enable,
	output logic [7:0]           r_data,
	output logic                 empty,
	output logic                 full
);

	usb_rx_pkg::rx_byte_t mem [usb_rx_pkg::FIFO_DEPTH];
	logic [usb_rx_pkg::PTR_W-1:0] wr_ptr;
	logic [usb_rx_pkg::PTR_W-1:0] rd_ptr;
	logic [usb_rx_pkg::CNT_W-1:0] count;
	logic do_write;
	logic do_read;

	function automatic logic [usb_rx_pkg::PTR_W-1:0] next_ptr(
		input logic [usb_rx_pkg::PTR_W-1:0] ptr
	);
		if (ptr == usb_rx_pkg::FIFO_DEPTH - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = count == '0;
	assign full = count == usb_rx_pkg::FIFO_DEPTH;
	assign do_write = byte_strobe && !full;
	assign do_read = r_enable && !empty;
	assign r_data = mem[rd_ptr].data;

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= byte_in;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_read)
				rd_ptr <= next_ptr(rd_ptr);

			// Push and pop together leave the count alone
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= usb_rx_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

/* hdl/usb_receiver.sv */
// Full-speed USB packet receiver, top level
// Line sampler feeds the receive FSM, which pushes bytes into the FIFO
`timescale 1ns/100ps
`default_nettype none

module usb_receiver (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       d_plus,
	input  logic       d_minus,
	input  logic       r_enable,
	output logic [7:0] r_data,
	output logic       empty,
	output logic       full,
	output logic       rcving,
	output logic       r_error
);

	logic bit_strobe;
	usb_rx_pkg::line_bit_t bit_evt;
	logic byte_strobe;
	usb_rx_pkg::rx_byte_t byte_out;

	line_sampler u_sampler (
		.clk        (clk),
		.rst_n      (rst_n),
		.d_plus     (d_plus),
		.d_minus    (d_minus),
		.bit_strobe (bit_strobe),
		.bit_evt    (bit_evt)
	);

	packet_control u_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.bit_strobe  (bit_strobe),
		.bit_evt     (bit_evt),
		.byte_strobe (byte_strobe),
		.byte_out    (byte_out),
		.rcving      (rcving),
		.r_error     (r_error)
	);

	rx_fifo u_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.byte_strobe (byte_strobe),
		.byte_in     (byte_out),
		.r_enable    (r_enable),
		.r_data      (r_data),
		.empty       (empty),
		.full        (full)
	);

endmodule

`default_nettype wire

/* test/clock_gen.sv */
// Free-running clock for the USB receiver testbench
// Starts low and toggles every half period
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

/* test/tb_usb_receiver.sv */
// Self-checking testbench for the full-speed USB receiver
// Drives NRZI packets onto d_plus/d_minus on the falling clock edge and
// reads the received bytes back through r_enable; assertions do the checking
`timescale 1ns/100ps
`default_nettype none

module tb_usb_receiver;

	localparam int BIT_CLKS = usb_rx_pkg::CLKS_PER_BIT;
	localparam int FIFO_SLOTS = usb_rx_pkg::FIFO_DEPTH;
	// KJKJKJKK on the wire, LSB first
	localparam logic [7:0] SYNC_PATTERN = 8'h80;
	// Starts with a transition but is not sync
	localparam logic [7:0] BAD_SYNC = 8'hC0;
	// Line bits per test, sync and data bytes plus three bit times of end of packet
	localparam int TEST_BITS = 11 + 35 + 27 + 28 + 91 + 38;
	// Reset, idle gaps and FIFO reads
	localparam int EXTRA_CLKS = 400;
	localparam int CYCLE_LIMIT = (TEST_BITS * BIT_CLKS + EXTRA_CLKS) * 3 / 2;

	logic clk;
	logic rst_n;
	logic d_plus;
	logic d_minus;
	logic r_enable;
	logic [7:0] r_data;
	logic empty;
	logic full;
	logic rcving;
	logic r_error;

	logic line_level;
	logic bad_packet;
	logic [31:0] lcg_state;
	logic [7:0] exp_q[$];
	int fail_cnt;
	int tests_passed;
	int tests_failed;
	int test_fail_base;
	string test_name;
	int cycle_cnt = 0;

	clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

	usb_receiver DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.d_plus   (d_plus),
		.d_minus  (d_minus),
		.r_enable (r_enable),
		.r_data   (r_data),
		.empty    (empty),
		.full     (full),
		.rcving   (rcving),
		.r_error  (r_error)
	);

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("[FAIL] %s expected 0x%02h got 0x%02h", name, expected, actual);
		fail_cnt++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		fail_cnt++;
	endtask

	task automatic expect_flag(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else
			report_mismatch(name, {7'b0, expected}, {7'b0, actual});
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_fail_base = fail_cnt;
	endtask

	task automatic finish_test();
		if (fail_cnt == test_fail_base)
		begin
			tests_passed++;
			$display("Test %-36s ok", test_name);
		end
		else
		begin
			tests_failed++;
			$display("Test %-36s FAILED with %0d errors", test_name, fail_cnt - test_fail_base);
		end
	endtask

	task automatic idle_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	// NRZI: a 0 toggles the line, a 1 holds it
	task automatic send_bit(input logic b);
		if (!b)
			line_level = !line_level;
		d_plus = line_level;
		d_minus = !line_level;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b);
		for (int i = 0; i < 8; i++)
			send_bit(b[i]);
	endtask

	// Two bit times of SE0, then one of idle J
	task automatic send_eop();
		d_plus = 1'b0;
		d_minus = 1'b0;
		repeat (2 * BIT_CLKS) @(negedge clk);
		line_level = 1'b1;
		d_plus = 1'b1;
		d_minus = 1'b0;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	// Random payload byte; bytes beyond a full FIFO are lost
	task automatic send_data_byte();
		logic [7:0] b;
		b = lcg_next();
		send_byte(b);
		if (exp_q.size() < FIFO_SLOTS)
			exp_q.push_back(b);
	endtask

	task automatic wait_for_byte();
		int n;
		n = 0;
		while (empty && n < 2 * BIT_CLKS)
		begin
			@(negedge clk);
			n++;
		end
		assert (!empty)
		else
			report_problem("no byte showed up in the FIFO within two bit times");
	endtask

	task automatic read_byte();
		logic [7:0] expected;
		wait_for_byte();
		if (exp_q.size() == 0)
			report_problem("FIFO holds a byte that was never expected");
		else
		begin
			expected = exp_q.pop_front();
			assert (r_data === expected)
			else
				report_mismatch("r_data", expected, r_data);
		end
		r_enable = 1'b1;
		@(negedge clk);
		r_enable = 1'b0;
	endtask

	// Reads n bytes and then expects the FIFO to be drained
	task automatic read_bytes(input int n);
		repeat (n) read_byte();
		expect_flag("empty", 1'b1, empty);
	endtask

	a_rcving_no_error: assert property (@(posedge clk) disable iff (!rst_n)
		rcving |-> !r_error)
		else report_mismatch("r_error", 8'h0, {7'b0, $sampled(r_error)});

	a_full_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		full |-> !empty)
		else report_mismatch("empty", 8'h0, {7'b0, $sampled(empty)});

	// A packet with a bad sync must never look like a reception
	a_bad_no_rcving: assert property (@(posedge clk) bad_packet |-> !rcving)
		else report_mismatch("rcving", 8'h0, {7'b0, $sampled(rcving)});

	a_bad_no_bytes: assert property (@(posedge clk) bad_packet |-> empty)
		else report_mismatch("empty", 8'h1, {7'b0, $sampled(empty)});

	a_reset_values: assert property (@(posedge clk)
		$rose(rst_n) |-> !rcving && !r_error && empty && !full)
		else report_problem("outputs were not at their reset values when reset was released");

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		d_plus = 1'b1;
		d_minus = 1'b0;
		r_enable = 1'b0;
		line_level = 1'b1;
		bad_packet = 1'b0;
		lcg_state = 32'd30;
		fail_cnt = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		idle_clocks(2 * BIT_CLKS);

		start_test("sync then end of packet");
		send_byte(SYNC_PATTERN);
		expect_flag("rcving", 1'b1, rcving);
		expect_flag("r_error", 1'b0, r_error);
		send_eop();
		expect_flag("rcving", 1'b0, rcving);
		expect_flag("r_error", 1'b0, r_error);
		expect_flag("empty", 1'b1, empty);
		finish_test();
		idle_clocks(2 * BIT_CLKS);

		start_test("three bytes read back in order");
		send_byte(SYNC_PATTERN);
		send_data_byte();
		// First byte falls through before its bit period ends
		expect_flag("empty", 1'b0, empty);
		assert (r_data === exp_q[0])
		else
			report_mismatch("r_data", exp_q[0], r_data);
		send_data_byte();
		send_data_byte();
		send_eop();
		expect_flag("r_error", 1'b0, r_error);
		read_bytes(3);
		finish_test();
		idle_clocks(2 * BIT_CLKS);

		start_test("wrong sync byte");
		bad_packet = 1'b1;
		send_byte(BAD_SYNC);
		expect_flag("r_error", 1'b1, r_error);
		send_byte(lcg_next());
		send_byte(lcg_next());
		send_eop();
		expect_flag("r_error", 1'b1, r_error);
		expect_flag("rcving", 1'b0, rcving);
		expect_flag("empty", 1'b1, empty);
		bad_packet = 1'b0;
		finish_test();
		idle_clocks(2 * BIT_CLKS);

		start_test("partial byte before end of packet");
		send_byte(SYNC_PATTERN);
		send_data_byte();
		send_data_byte();
		send_bit(1'b0);
		send_eop();
		expect_flag("r_error", 1'b1, r_error);
		expect_flag("rcving", 1'b0, rcving);
		read_bytes(2);
		finish_test();
		idle_clocks(2 * BIT_CLKS);

		start_test("ten bytes into a full FIFO");
		send_byte(SYNC_PATTERN);
		repeat (FIFO_SLOTS - 1) send_data_byte();
		expect_flag("full", 1'b0, full);
		send_data_byte();
		expect_flag("full", 1'b1, full);
		// These two are dropped
		send_data_byte();
		send_data_byte();
		send_eop();
		expect_flag("full", 1'b1, full);
		read_bytes(FIFO_SLOTS);
		finish_test();
		idle_clocks(2 * BIT_CLKS);

		start_test("good packet after an error");
		bad_packet = 1'b1;
		send_byte(BAD_SYNC);
		send_eop();
		expect_flag("r_error", 1'b1, r_error);
		bad_packet = 1'b0;
		idle_clocks(2 * BIT_CLKS);
		send_byte(SYNC_PATTERN);
		expect_flag("r_error", 1'b0, r_error);
		expect_flag("rcving", 1'b1, rcving);
		send_data_byte();
		send_data_byte();
		send_eop();
		expect_flag("r_error", 1'b0, r_error);
		read_bytes(2);
		finish_test();
		idle_clocks(2 * BIT_CLKS);

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, fail_cnt);
		if (fail_cnt == 0 && tests_failed == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hdl/usb_rx_pkg.sv
hdl/line_sampler.sv
hdl/packet_control.sv
hdl/rx_fifo.sv
hdl/usb_receiver.sv
test/clock_gen.sv
test/tb_usb_receiver.sv
